/* logic/besm_pkg.sv */
package besm_pkg;

    localparam int WORD_W     = 64;     // Y and D bus width
    localparam int MR_W       = 32;     // Modifier word width
    localparam int GROUP_BITS = 5;      // Modifier group number
    localparam int PAGE_BITS  = 10;     // Physical page index

    // Control fields of one microinstruction
    typedef struct packed {
        logic       rsvd;               // Spare, pads to 40 bits
        logic [3:0] dsrc;               // D bus source
        logic [3:0] ydst;               // Y bus destination
        logic [2:0] ydev;               // Y-side device
        logic       wry;                // Y-side device write
        logic [2:0] ddev;               // D-side device
        logic       wrd;                // D-side device write
        logic       csm;                // Modifier memory access
        logic       wem;                // Modifier memory write
        logic       mod;                // Privileged access
        logic [1:0] mnsa;               // Modifier number source
        logic [4:0] modnm;              // Modifier number, inverted
        logic       iomp;               // Low selects flag decoder
        logic [4:0] ffcnt;              // Flag set/clear code
        logic       ise;                // Copy tkk into rcb
        logic [4:0] cond;               // Condition select
        logic       icc;                // Condition pass-through
    } micro_t;

    // Mode register RR, bit 31 first
    typedef struct packed {
        logic [1:0] rr_unused;          // Not specified
        logic       flag_jump;          // Jump instruction flag
        logic       rcb;                // Right instruction flag
        logic       cb;                 // Address changed by M16
        logic       no_paging;          // Paging blocked
        logic       no_procnm;          // Process number check blocked
        logic       flag_negaddr;       // Negative address mode
        logic       no_rprot;           // Read protection off
        logic       no_wprot;           // Write protection off
        logic       intstp;             // Stop on interrupt
        logic       single_step;        // Single step mode
        logic       cemlrg;             // Reserved bit 19
        logic       no_wtag;            // Write tag check off
        logic       no_intr;            // External interrupts masked
        logic       no_progtag;         // Tag interpretation off
        logic       no_badacc;          // Foreign accumulator ignored
        logic       no_rtag;            // Read tag check off
        logic       no_badop;           // Foreign operand ignored
        logic       drg;                // Dispatcher mode
        logic       ovrftb;             // Field overflow check off
        logic       bnb;                // BESM-6 range check off
        logic       flag_z;             // Zero
        logic       flag_n;             // Negative
        logic       flag_c;             // Carry
        logic       flag_v;             // Overflow
        logic       ovrib;              // Overflow interrupt blocked
        logic [2:0] grp;                // Branch condition group
        logic       rndb;               // Rounding blocked
        logic       normb;              // Normalization blocked
    } mode_t;

    // --------------------
    // D bus sources and Y bus destinations
    localparam logic [3:0] DSRC_GROUP = 4'd1, DSRC_PROCN = 4'd2;
    localparam logic [3:0] DSRC_RR    = 4'd3, DSRC_PAGE  = 4'd4;
    localparam logic [3:0] YDST_GROUP = 4'd1, YDST_PROCN = 4'd2;
    localparam logic [3:0] YDST_RR    = 4'd3, YDST_PAGE  = 4'd4;
    localparam logic [3:0] YDST_UREG  = 4'd8;

    // Device codes
    localparam logic [2:0] YDEV_UREG   = 3'd3, YDEV_PSMEM = 3'd4;
    localparam logic [2:0] DDEV_ACCESS = 3'd1, DDEV_REPRI = 3'd2;
    localparam logic [2:0] DDEV_CLRCB  = 3'd3;

    // --------------------
    // Flag decoder codes
    localparam logic [4:0] FF_LOGGRP = 5'd1,  FF_MULGRP = 5'd2,  FF_ADDGRP = 5'd3;
    localparam logic [4:0] FF_SETC   = 5'd5,  FF_CLRRCB = 5'd6,  FF_SETRCB = 5'd7;
    localparam logic [4:0] FF_CLRJMP = 5'd8,  FF_SETJMP = 5'd9;
    localparam logic [4:0] FF_SETEI  = 5'd10, FF_CLREI  = 5'd11;
    localparam logic [4:0] FF_CLRTR0 = 5'd12, FF_SETTR0 = 5'd13;
    localparam logic [4:0] FF_CLRTR1 = 5'd14, FF_SETTR1 = 5'd15;
    localparam logic [4:0] FF_CLRTKK = 5'd18, FF_SETTKK = 5'd19;
    localparam logic [4:0] FF_SETNR  = 5'd20, FF_SETER  = 5'd22;
    localparam logic [4:0] FF_CHTKK  = 5'd23;

endpackage

/* logic/modifier_mem.sv */
`timescale 1ns/1ps

module modifier_mem #(
    parameter int GROUP_BITS = besm_pkg::GROUP_BITS
) (
    input  logic                        clk,
    input  logic                        reset,
    input  besm_pkg::micro_t            i_micro,
    input  logic [besm_pkg::WORD_W-1:0] i_y,
    input  logic [4:0]                  i_ureg_low,
    output logic [GROUP_BITS-1:0]       o_group,
    output logic [besm_pkg::MR_W-1:0]   o_mr_read
);
    import besm_pkg::*;

    localparam int DEPTH = 2 ** (GROUP_BITS + 5);   // 32 modifiers per group

    logic [GROUP_BITS-1:0] group;                   // Group number register
    logic [MR_W-1:0]       mem [DEPTH];
    logic [4:0]            mn;                      // Modifier number
    logic [GROUP_BITS+4:0] addr;
    logic                  not_mp;                  // Number not from microinstruction
    logic                  hi_locked;               // M16..M31 without privilege
    logic                  wr_ok;

    always_comb begin
        case (i_micro.mnsa)
            2'd0:    mn = i_ureg_low;               // From UREG
            2'd3:    mn = ~i_micro.modnm;           // Microinstruction field, inverted
            default: mn = '0;                       // Instruction field maps to M0
        endcase
    end

    assign not_mp    = (i_micro.mnsa != 2'd3);
    assign hi_locked = mn[4] & not_mp & ~i_micro.mod;
    assign addr      = {group, mn};
    // M0 is write-protected unless named directly
    assign wr_ok     = i_micro.csm & i_micro.wem & ~hi_locked & ~((mn == 5'd0) & not_mp);

    always_ff @(posedge clk) begin
        if (reset) begin
            group <= '0;
        end else if (i_micro.ydst == YDST_GROUP) begin
            group <= i_y[5 +: GROUP_BITS];          // Y bits 9:5
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[addr] <= i_y[MR_W-1:0];
        end
    end

    assign o_mr_read = hi_locked ? '0 : mem[addr];
    assign o_group   = group;

endmodule

/* logic/page_unit.sv */
`timescale 1ns/1ps

module page_unit #(
    parameter int PAGE_BITS = besm_pkg::PAGE_BITS
) (
    input  logic                        clk,
    input  logic                        reset,
    input  besm_pkg::micro_t            i_micro,
    input  logic [besm_pkg::WORD_W-1:0] i_y,
    output logic [31:0]                 o_ureg,
    output logic [4:0]                  o_ureg_low,
    output logic [PAGE_BITS-1:0]        o_pg_index,
    output logic [2:0]                  o_pg_access,
    output logic                        o_pg_repri,
    output logic [19:0]                 o_map_word
);
    import besm_pkg::*;

    localparam int PAGES = 2 ** PAGE_BITS;

    logic [31:0]          ureg;                 // Executive address
    logic [PAGE_BITS-1:0] pg_index;             // Physical page register
    logic [PAGE_BITS-1:0] ureg_page;            // Page field of UREG
    logic [19:0]          pg_map [PAGES];       // Page map
    logic                 pg_inv [PAGES];       // Access blocked
    logic                 pg_ro [PAGES];        // Modification blocked
    logic                 pg_repri [PAGES];     // Priority list change

    assign ureg_page = ureg[10 +: PAGE_BITS];   // UREG bits 19:10

    always_ff @(posedge clk) begin
        if (reset) begin
            ureg     <= '0;
            pg_index <= '0;
        end else begin
            if (i_micro.ydst == YDST_UREG)
                ureg <= i_y[31:0];
            if (i_micro.ydst == YDST_PAGE)
                pg_index <= i_y[10 +: PAGE_BITS];
        end
    end

    // --------------------
    // Page map and per-page bits
    always_ff @(posedge clk) begin
        if (i_micro.wry && i_micro.ydev == YDEV_PSMEM)
            pg_map[ureg_page] <= i_y[19:0];
        if (i_micro.wrd && i_micro.ddev == DDEV_ACCESS) begin
            pg_inv[pg_index] <= i_y[1];
            pg_ro[pg_index]  <= i_y[2];
        end
        if (i_micro.wrd && i_micro.ddev == DDEV_REPRI)
            pg_repri[pg_index] <= i_y[0];
    end

    assign o_pg_access = {pg_ro[pg_index], pg_inv[pg_index], 1'b0};
    assign o_pg_repri  = pg_repri[pg_index];
    assign o_map_word  = pg_map[ureg_page];     // Entry of current UREG page
    assign o_ureg      = ureg;
    assign o_ureg_low  = ureg[4:0];             // Modifier number
    assign o_pg_index  = pg_index;

endmodule

/* logic/mode_reg.sv */
`timescale 1ns/1ps

module mode_reg (
    input  logic                        clk,
    input  logic                        reset,
    input  besm_pkg::micro_t            i_micro,
    input  logic [besm_pkg::WORD_W-1:0] i_y,
    output besm_pkg::mode_t             o_mode,
    output logic [7:0]                  o_procn,
    output logic                        o_cond
);
    import besm_pkg::*;

    mode_t      rr;                 // Mode register
    logic [7:0] procn;              // Process number
    logic       tr0;                // Microprogram flag 0
    logic       tr1;                // Microprogram flag 1
    logic       tkk;                // Standardizer right half
    logic       besm6_mode;         // Emulation mode
    logic       cond;

    // --------------------
    // Register loads and flag decoder
    // Later statements override the RR load in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rr         <= '0;
            procn      <= '0;
            tr0        <= 1'b0;
            tr1        <= 1'b0;
            tkk        <= 1'b0;
            besm6_mode <= 1'b0;
        end else begin
            if (i_micro.ydst == YDST_RR)
                rr <= i_y[31:0];
            if (i_micro.ydst == YDST_PROCN)
                procn <= i_y[7:0];

            if (!i_micro.iomp) begin
                case (i_micro.ffcnt)
                    FF_LOGGRP: rr.grp       <= 3'b001;  // Logic group
                    FF_MULGRP: rr.grp       <= 3'b010;  // Multiply group
                    FF_ADDGRP: rr.grp       <= 3'b100;  // Add group
                    FF_SETC:   rr.cb        <= 1'b1;
                    FF_CLRRCB: rr.rcb       <= 1'b0;
                    FF_SETRCB: rr.rcb       <= 1'b1;
                    FF_CLRJMP: rr.flag_jump <= 1'b0;
                    FF_SETJMP: rr.flag_jump <= 1'b1;
                    FF_SETEI:  rr.no_intr   <= 1'b0;    // Interrupts enabled
                    FF_CLREI:  rr.no_intr   <= 1'b1;    // Interrupts masked
                    FF_CLRTR0: tr0          <= 1'b0;
                    FF_SETTR0: tr0          <= 1'b1;
                    FF_CLRTR1: tr1          <= 1'b0;
                    FF_SETTR1: tr1          <= 1'b1;
                    FF_CLRTKK: tkk          <= 1'b0;
                    FF_SETTKK: tkk          <= 1'b1;
                    FF_CHTKK:  tkk          <= ~tkk;    // Toggle
                    FF_SETNR:  besm6_mode   <= 1'b0;    // Native mode
                    FF_SETER:  besm6_mode   <= 1'b1;    // Emulation mode
                    default: ;
                endcase
            end

            if (i_micro.ise)
                rr.rcb <= tkk;                          // Beats FF set/clear
            if (i_micro.ddev == DDEV_CLRCB)
                rr.cb <= 1'b0;                          // Clear beats FF set
        end
    end

    // --------------------
    // Condition multiplexer
    always_comb begin
        case (i_micro.cond)
            5'd1:    cond = rr.normb;
            5'd2:    cond = rr.rndb;
            5'd3:    cond = rr.ovrib;
            5'd4:    cond = rr.bnb;
            5'd5:    cond = rr.ovrftb;
            5'd6:    cond = rr.drg;
            5'd7:    cond = besm6_mode;
            5'd8:    cond = rr.rcb;
            5'd9:    cond = rr.cb;
            5'd10:   cond = rr.cemlrg;
            5'd12:   cond = tr1;
            5'd13:   cond = rr.intstp;
            5'd15:   cond = tkk;
            5'd22:   cond = tr0;
            default: cond = 1'b1;                       // Unconditional and dropped codes
        endcase
    end

    assign o_cond  = i_micro.icc ? cond : ~cond;
    assign o_mode  = rr;
    assign o_procn = procn;

endmodule

/* logic/bus_source_mux.sv */
`timescale 1ns/1ps

module bus_source_mux #(
    parameter int GROUP_BITS = besm_pkg::GROUP_BITS,
    parameter int PAGE_BITS  = besm_pkg::PAGE_BITS
) (
    input  besm_pkg::micro_t            i_micro,
    input  logic [GROUP_BITS-1:0]       i_group,
    input  logic [7:0]                  i_procn,
    input  besm_pkg::mode_t             i_mode,
    input  logic [PAGE_BITS-1:0]        i_pg_index,
    input  logic [2:0]                  i_pg_access,
    input  logic                        i_pg_repri,
    input  logic [besm_pkg::MR_W-1:0]   i_mr_read,
    input  logic [31:0]                 i_ureg,
    input  logic [19:0]                 i_map_word,
    output logic [besm_pkg::WORD_W-1:0] o_d,
    output logic [31:0]                 o_yread
);
    import besm_pkg::*;

    // D bus, first match wins, zero-extended
    always_comb begin
        o_d = '0;
        if (i_micro.dsrc == DSRC_GROUP)
            o_d[GROUP_BITS+5:0] = {1'b1, i_group, 5'd0};
        else if (i_micro.dsrc == DSRC_PROCN)
            o_d[7:0] = i_procn;
        else if (i_micro.dsrc == DSRC_RR)
            o_d[31:0] = i_mode;
        else if (i_micro.dsrc == DSRC_PAGE)
            o_d[PAGE_BITS+9:0] = {i_pg_index, 10'd0};
        else if (i_micro.ddev == DDEV_ACCESS)
            o_d[2:0] = i_pg_access;                 // Read-only, invalid, 0
        else if (i_micro.ddev == DDEV_REPRI)
            o_d[0] = i_pg_repri;
        else if (i_micro.csm && !i_micro.wem)
            o_d[MR_W-1:0] = i_mr_read;              // Modifier read
    end

    // Y-side reads, only when the device is not being written
    always_comb begin
        o_yread = '0;
        if (!i_micro.wry && i_micro.ydev == YDEV_UREG)
            o_yread = i_ureg;
        else if (!i_micro.wry && i_micro.ydev == YDEV_PSMEM)
            o_yread[19:0] = i_map_word;
    end

endmodule

/* logic/besm_sregs.sv */
`timescale 1ns/1ps

module besm_sregs #(
    parameter int GROUP_BITS = besm_pkg::GROUP_BITS,
    parameter int PAGE_BITS  = besm_pkg::PAGE_BITS
) (
    input  logic                        clk,
    input  logic                        reset,
    input  besm_pkg::micro_t            i_micro,
    input  logic [besm_pkg::WORD_W-1:0] i_y,
    output logic [besm_pkg::WORD_W-1:0] o_d,
    output logic [31:0]                 o_yread,
    output logic                        o_cond
);
    import besm_pkg::*;

    logic [GROUP_BITS-1:0] group;
    logic [MR_W-1:0]       mr_read;
    logic [31:0]           ureg;
    logic [4:0]            ureg_low;            // Modifier number from UREG
    logic [PAGE_BITS-1:0]  pg_index;
    logic [2:0]            pg_access;
    logic                  pg_repri;
    logic [19:0]           map_word;
    mode_t                 mode;
    logic [7:0]            procn;

    // --------------------
    // Register peers, all written from Y
    modifier_mem #(.GROUP_BITS(GROUP_BITS)) u_modifier_mem (
        .clk(clk), .reset(reset), .i_micro(i_micro), .i_y(i_y),
        .i_ureg_low(ureg_low), .o_group(group), .o_mr_read(mr_read));

    page_unit #(.PAGE_BITS(PAGE_BITS)) u_page_unit (
        .clk(clk), .reset(reset), .i_micro(i_micro), .i_y(i_y),
        .o_ureg(ureg), .o_ureg_low(ureg_low), .o_pg_index(pg_index),
        .o_pg_access(pg_access), .o_pg_repri(pg_repri), .o_map_word(map_word));

    mode_reg u_mode_reg (
        .clk(clk), .reset(reset), .i_micro(i_micro), .i_y(i_y),
        .o_mode(mode), .o_procn(procn), .o_cond(o_cond));

    bus_source_mux #(.GROUP_BITS(GROUP_BITS), .PAGE_BITS(PAGE_BITS)) u_bus_source_mux (
        .i_micro(i_micro), .i_group(group), .i_procn(procn), .i_mode(mode),
        .i_pg_index(pg_index), .i_pg_access(pg_access), .i_pg_repri(pg_repri),
        .i_mr_read(mr_read), .i_ureg(ureg), .i_map_word(map_word),
        .o_d(o_d), .o_yread(o_yread));

endmodule

/* sim/tb_ref.svh */
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Shadow of the DUT state, updated as each write is driven
mode_t                 s_rr;
logic [7:0]            s_procn;
logic                  s_tr0;
logic                  s_tr1;
logic                  s_tkk;
logic                  s_emul;                      // BESM-6 emulation mode
logic [GROUP_BITS-1:0] s_group;
logic [31:0]           s_ureg;
logic [PAGE_BITS-1:0]  s_pg;
logic [31:0]           s_mr [2 ** (GROUP_BITS + 5)];
logic [19:0]           s_map [2 ** PAGE_BITS];
logic [2:0]            s_acc [2 ** PAGE_BITS];      // Read-only, invalid, 0
logic                  s_repri [2 ** PAGE_BITS];

task automatic shadow_reset();
    s_rr    = '0;
    s_procn = '0;
    s_tr0   = 1'b0;
    s_tr1   = 1'b0;
    s_tkk   = 1'b0;
    s_emul  = 1'b0;
    s_group = '0;
    s_ureg  = '0;
    s_pg    = '0;
endtask

function automatic logic [4:0] ref_mnum(micro_t m);
    case (m.mnsa)
        2'd0:    return s_ureg[4:0];
        2'd3:    return ~m.modnm;
        default: return 5'd0;                       // Instruction field gives M0
    endcase
endfunction

// Upper modifiers hidden from unprivileged indirect access
function automatic logic ref_locked(micro_t m);
    return (ref_mnum(m) >= 5'd16) && (m.mnsa != 2'd3) && !m.mod;
endfunction

function automatic logic [63:0] ref_d(micro_t m);
    logic [63:0] d;
    d = '0;
    if (m.dsrc == DSRC_GROUP)
        d = (64'd1 << (GROUP_BITS + 5)) | (64'(s_group) << 5);
    else if (m.dsrc == DSRC_PROCN)
        d = 64'(s_procn);
    else if (m.dsrc == DSRC_RR)
        d = 64'(s_rr);
    else if (m.dsrc == DSRC_PAGE)
        d = 64'(s_pg) << 10;
    else if (m.ddev == DDEV_ACCESS)
        d = 64'(s_acc[s_pg]);
    else if (m.ddev == DDEV_REPRI)
        d = 64'(s_repri[s_pg]);
    else if (m.csm && !m.wem && !ref_locked(m))
        d = 64'(s_mr[{s_group, ref_mnum(m)}]);
    return d;
endfunction

function automatic logic [31:0] ref_yread(micro_t m);
    if (!m.wry && m.ydev == YDEV_UREG)
        return s_ureg;
    if (!m.wry && m.ydev == YDEV_PSMEM)
        return 32'(s_map[s_ureg[10 +: PAGE_BITS]]);
    return 32'd0;
endfunction

function automatic logic ref_cond(micro_t m);
    logic c;
    case (m.cond)
        5'd1:    c = s_rr.normb;
        5'd2:    c = s_rr.rndb;
        5'd3:    c = s_rr.ovrib;
        5'd4:    c = s_rr.bnb;
        5'd5:    c = s_rr.ovrftb;
        5'd6:    c = s_rr.drg;
        5'd7:    c = s_emul;
        5'd8:    c = s_rr.rcb;
        5'd9:    c = s_rr.cb;
        5'd10:   c = s_rr.cemlrg;
        5'd12:   c = s_tr1;
        5'd13:   c = s_rr.intstp;
        5'd15:   c = s_tkk;
        5'd22:   c = s_tr0;
        default: c = 1'b1;                          // Always true
    endcase
    return m.icc ? c : !c;
endfunction

// Applies one cycle's writes, memories first with the old addresses
task automatic shadow_write(micro_t m, logic [63:0] y);
    logic old_tkk;
    old_tkk = s_tkk;
    if (m.csm && m.wem && !ref_locked(m) && !(ref_mnum(m) == 5'd0 && m.mnsa != 2'd3))
        s_mr[{s_group, ref_mnum(m)}] = y[31:0];
    if (m.wry && m.ydev == YDEV_PSMEM)
        s_map[s_ureg[10 +: PAGE_BITS]] = y[19:0];
    if (m.wrd && m.ddev == DDEV_ACCESS)
        s_acc[s_pg] = {y[2], y[1], 1'b0};
    if (m.wrd && m.ddev == DDEV_REPRI)
        s_repri[s_pg] = y[0];
    case (m.ydst)
        YDST_GROUP: s_group = y[5 +: GROUP_BITS];
        YDST_PROCN: s_procn = y[7:0];
        YDST_RR:    s_rr    = y[31:0];
        YDST_PAGE:  s_pg    = y[10 +: PAGE_BITS];
        YDST_UREG:  s_ureg  = y[31:0];
        default: ;
    endcase
    if (!m.iomp) begin
        case (m.ffcnt)
            FF_LOGGRP: s_rr.grp       = 3'b001;
            FF_MULGRP: s_rr.grp       = 3'b010;
            FF_ADDGRP: s_rr.grp       = 3'b100;
            FF_SETC:   s_rr.cb        = 1'b1;
            FF_CLRRCB: s_rr.rcb       = 1'b0;
            FF_SETRCB: s_rr.rcb       = 1'b1;
            FF_CLRJMP: s_rr.flag_jump = 1'b0;
            FF_SETJMP: s_rr.flag_jump = 1'b1;
            FF_SETEI:  s_rr.no_intr   = 1'b0;
            FF_CLREI:  s_rr.no_intr   = 1'b1;
            FF_CLRTR0: s_tr0          = 1'b0;
            FF_SETTR0: s_tr0          = 1'b1;
            FF_CLRTR1: s_tr1          = 1'b0;
            FF_SETTR1: s_tr1          = 1'b1;
            FF_CLRTKK: s_tkk          = 1'b0;
            FF_SETTKK: s_tkk          = 1'b1;
            FF_CHTKK:  s_tkk          = !old_tkk;
            FF_SETNR:  s_emul         = 1'b0;
            FF_SETER:  s_emul         = 1'b1;
            default: ;
        endcase
    end
    if (m.ise)
        s_rr.rcb = old_tkk;                         // Copy wins over set/clear
    if (m.ddev == DDEV_CLRCB)
        s_rr.cb = 1'b0;                             // Clear wins over set
endtask

`endif

/* sim/tb_besm_sregs.sv */
`timescale 1ns/1ps

module tb_besm_sregs;
    import besm_pkg::*;

    localparam int N_RR   = 20;             // RR and process number rounds
    localparam int N_FF   = 60;             // Random flag codes
    localparam int N_MOD  = 16;
    localparam int N_UREG = 8;
    localparam int N_PG   = 16;
    localparam int MAX_CYCLES = 16 + N_RR * 4 + N_FF * 2 + N_MOD * 4 + N_UREG * 6
                                + N_PG * 10 + 100;

    logic        clk;
    logic        reset;
    micro_t      i_micro;
    logic [63:0] i_y;
    logic [63:0] o_d;
    logic [31:0] o_yread;
    logic        o_cond;

    logic        chk_en;                    // Current cycle is a read
    logic [63:0] exp_d;
    logic [31:0] exp_yread;
    logic        exp_cond;
    int          n_checks = 0;
    int          n_errors = 0;
    int          cycles = 0;
    int          err_mark;                  // Errors before the running test
    logic [4:0]  ff_codes [19];
    logic [4:0]  flag_conds [4];            // Condition codes of flags outside RR

    `include "tb_ref.svh"

    besm_sregs #(.GROUP_BITS(GROUP_BITS), .PAGE_BITS(PAGE_BITS)) dut0 (
        .clk(clk), .reset(reset), .i_micro(i_micro), .i_y(i_y),
        .o_d(o_d), .o_yread(o_yread), .o_cond(o_cond));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // --------------------
    // Checker samples mid-cycle where outputs have settled
    always @(negedge clk) begin
        if (chk_en) begin
            n_checks = n_checks + 1;
            if (o_d !== exp_d) begin
                $display("[FAIL] t=%0t o_d: got %h, expected %h", $time, o_d, exp_d);
                n_errors = n_errors + 1;
            end
            if (o_yread !== exp_yread) begin
                $display("[FAIL] t=%0t o_yread: got %h, expected %h", $time, o_yread, exp_yread);
                n_errors = n_errors + 1;
            end
            if (o_cond !== exp_cond) begin
                $display("[FAIL] t=%0t o_cond: got %b, expected %b", $time, o_cond, exp_cond);
                n_errors = n_errors + 1;
            end
        end
    end

    function automatic micro_t idle();
        micro_t m;
        m = '0;
        m.iomp = 1'b1;                      // Flag decoder off
        return m;
    endfunction

    function automatic logic [63:0] rand_word();
        return {$urandom, $urandom};
    endfunction

    // --------------------
    // Stimulus driven 1 ns after the rising edge
    task automatic drive(micro_t m, logic [63:0] y, bit check);
        @(posedge clk);
        #1;
        if (check) begin
            if (m.cond == 5'd0)
                m.cond = 5'($urandom);      // Any condition unless one is named
            m.icc  = 1'($urandom);
            exp_d     = ref_d(m);
            exp_yread = ref_yread(m);
            exp_cond  = ref_cond(m);
        end
        i_micro = m;
        i_y     = y;
        chk_en  = check;
        shadow_write(m, y);
    endtask

    task automatic load(logic [3:0] dst, logic [63:0] y);
        micro_t m;
        m = idle();
        m.ydst = dst;
        drive(m, y, 1'b0);
    endtask

    task automatic flag_op(logic [4:0] ff, logic ise, logic [2:0] ddev);
        micro_t m;
        m = idle();
        m.iomp  = 1'b0;
        m.ffcnt = ff;
        m.ise   = ise;
        m.ddev  = ddev;
        drive(m, 64'd0, 1'b0);
    endtask

    task automatic read_src(logic [3:0] src);
        micro_t m;
        m = idle();
        m.dsrc = src;
        drive(m, 64'd0, 1'b1);
    endtask

    task automatic read_rr_cond(logic [4:0] sel);
        micro_t m;
        m = idle();
        m.dsrc = DSRC_RR;
        m.cond = sel;
        drive(m, 64'd0, 1'b1);
    endtask

    task automatic mod_cycle(logic [1:0] mnsa, logic [4:0] num, logic priv, logic wem,
                             logic [63:0] y);
        micro_t m;
        m = idle();
        m.csm   = 1'b1;
        m.wem   = wem;
        m.mod   = priv;
        m.mnsa  = mnsa;
        m.modnm = ~num;                     // Field carries the inverted number
        drive(m, y, !wem);
    endtask

    task automatic dev_cycle(logic [2:0] ydev, logic wry, logic [2:0] ddev, logic wrd,
                             logic [63:0] y);
        micro_t m;
        m = idle();
        m.ydev = ydev;
        m.wry  = wry;
        m.ddev = ddev;
        m.wrd  = wrd;
        drive(m, y, !(wry || wrd));
    endtask

    task automatic end_test(string name);
        @(posedge clk);
        #1;
        chk_en  = 1'b0;
        i_micro = idle();
        if (n_errors == err_mark)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d errors", name, n_errors - err_mark);
        err_mark = n_errors;
    endtask

    initial begin
        logic [4:0]  k;
        logic [4:0]  sel;
        logic [63:0] v;
        void'($urandom(32'hc47cd0b3));
        ff_codes = '{FF_LOGGRP, FF_MULGRP, FF_ADDGRP, FF_SETC, FF_CLRRCB, FF_SETRCB,
                     FF_CLRJMP, FF_SETJMP, FF_SETEI, FF_CLREI, FF_CLRTR0, FF_SETTR0,
                     FF_CLRTR1, FF_SETTR1, FF_CLRTKK, FF_SETTKK, FF_SETNR, FF_SETER,
                     FF_CHTKK};
        flag_conds = '{5'd7, 5'd12, 5'd15, 5'd22};  // besm6_mode, tr1, tkk, tr0
        reset    = 1'b1;
        i_micro  = idle();
        i_y      = '0;
        chk_en   = 1'b0;
        err_mark = 0;
        shadow_reset();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        read_src(DSRC_GROUP);
        read_src(DSRC_PROCN);
        read_src(DSRC_RR);
        read_src(DSRC_PAGE);
        end_test("reset values");

        for (int i = 0; i < N_RR; i++) begin
            load(YDST_RR, rand_word());
            read_src(DSRC_RR);
            load(YDST_PROCN, rand_word());
            read_src(DSRC_PROCN);
        end
        for (int i = 0; i < N_FF; i++) begin
            sel = 5'($urandom % 19);
            flag_op(ff_codes[sel], 1'b0, 3'd0);
            read_rr_cond(flag_conds[2'(i)]);  // Rotates over the flags outside RR
        end
        end_test("mode register and flags");

        flag_op(FF_SETC, 1'b0, DDEV_CLRCB);  // Same-cycle set and clear
        read_src(DSRC_RR);
        flag_op(FF_SETC, 1'b0, 3'd0);
        read_src(DSRC_RR);
        flag_op(5'd0, 1'b0, DDEV_CLRCB);
        read_src(DSRC_RR);
        flag_op(FF_SETTKK, 1'b0, 3'd0);
        flag_op(FF_CLRRCB, 1'b1, 3'd0);      // Copy against clear
        read_src(DSRC_RR);
        flag_op(FF_CHTKK, 1'b0, 3'd0);
        flag_op(FF_SETRCB, 1'b1, 3'd0);      // Copy against set
        read_src(DSRC_RR);
        flag_op(FF_SETRCB, 1'b0, 3'd0);
        read_src(DSRC_RR);
        flag_op(FF_CHTKK, 1'b0, 3'd0);
        read_src(DSRC_RR);
        end_test("cb and rcb priority");

        for (int i = 0; i < N_MOD; i++) begin
            k = 5'($urandom);
            load(YDST_GROUP, rand_word());
            read_src(DSRC_GROUP);
            mod_cycle(2'd3, k, 1'b0, 1'b1, rand_word());
            mod_cycle(2'd3, k, 1'b0, 1'b0, 64'd0);
        end
        for (int i = 0; i < N_UREG; i++) begin
            k = 5'(16 + $urandom % 16);
            v = rand_word();
            v[4:0] = k;
            load(YDST_UREG, v);
            mod_cycle(2'd3, k, 1'b0, 1'b1, rand_word());
            mod_cycle(2'd0, 5'd0, 1'b0, 1'b1, rand_word());  // Unprivileged write is dropped
            mod_cycle(2'd0, 5'd0, 1'b0, 1'b0, 64'd0);
            mod_cycle(2'd0, 5'd0, 1'b1, 1'b0, 64'd0);
            mod_cycle(2'd3, k, 1'b0, 1'b0, 64'd0);
        end
        v = rand_word();
        v[4:0] = 5'd0;
        load(YDST_UREG, v);
        mod_cycle(2'd3, 5'd0, 1'b0, 1'b1, rand_word());
        mod_cycle(2'd0, 5'd0, 1'b1, 1'b1, rand_word());      // M0 through UREG
        mod_cycle(2'd1, 5'd0, 1'b0, 1'b0, 64'd0);
        v = rand_word();
        v[4:0] = 5'(1 + $urandom % 15);
        k = v[4:0];
        load(YDST_UREG, v);
        mod_cycle(2'd0, 5'd0, 1'b0, 1'b1, rand_word());
        mod_cycle(2'd3, k, 1'b0, 1'b0, 64'd0);
        end_test("modifier memory");

        for (int i = 0; i < N_PG; i++) begin
            load(YDST_UREG, rand_word());
            dev_cycle(YDEV_PSMEM, 1'b1, 3'd0, 1'b0, rand_word());
            dev_cycle(YDEV_PSMEM, 1'b0, 3'd0, 1'b0, 64'd0);
            dev_cycle(YDEV_UREG, 1'b0, 3'd0, 1'b0, 64'd0);
        end
        for (int i = 0; i < N_PG; i++) begin
            load(YDST_PAGE, rand_word());
            dev_cycle(3'd0, 1'b0, DDEV_ACCESS, 1'b1, rand_word());
            dev_cycle(3'd0, 1'b0, DDEV_REPRI, 1'b1, rand_word());
            dev_cycle(3'd0, 1'b0, DDEV_ACCESS, 1'b0, 64'd0);
            dev_cycle(3'd0, 1'b0, DDEV_REPRI, 1'b0, 64'd0);
            read_src(DSRC_PAGE);
        end
        end_test("page unit");

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* besm_sregs.f */
+incdir+sim
logic/besm_pkg.sv
logic/modifier_mem.sv
logic/page_unit.sv
logic/mode_reg.sv
logic/bus_source_mux.sv
logic/besm_sregs.sv
sim/tb_besm_sregs.sv

/* run.sh */
#!/bin/sh
# Build and run the special-register testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_besm_sregs -f besm_sregs.f

out=$(./obj_dir/Vtb_besm_sregs)
echo "$out"

if echo "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
